/* verilog.f */
source/pong_pkg.sv
source/vga_timing.sv
source/paddle_ctrl.sv
source/ball_ctrl.sv
source/game_main.sv
source/pong_top.sv
testbench/pong_assertions.sv
testbench/pong_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -f verilog.f --top-module pong_tb -o pong_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/pong_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* testbench/pong_tb.sv */
// ------------------------------
// pong testbench
// clock, reset, DUT, checks,
// six directed tests
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module pong_tb
  import pong_pkg::*;
();

  localparam int TOTAL_COLS    = 800;
  localparam int TOTAL_ROWS    = 525;
  localparam int ACTIVE_COLS   = 640;
  localparam int ACTIVE_ROWS   = 480;
  localparam int PADDLE_HEIGHT = 6;
  localparam int GAME_SPEED    = 2000;
  localparam int SCORE_TO_WIN  = 5;
  localparam int BOARD_W       = ACTIVE_COLS >> CELL_SHIFT;
  localparam int RESET_CYCLES  = 16;
  localparam int FRAME_CYCLES  = TOTAL_COLS * TOTAL_ROWS;
  localparam int SYNC_TIMEOUT  = FRAME_CYCLES + TOTAL_COLS;
  localparam int RALLY_TIMEOUT = 200 * GAME_SPEED;

  logic               clk;
  logic               rst;
  logic               start;
  logic               p1_up;
  logic               p1_down;
  logic               p2_up;
  logic               p2_down;
  logic               hsync;
  logic               vsync;
  logic [2:0]         vga_r;
  logic [2:0]         vga_g;
  logic [2:0]         vga_b;
  logic [SCORE_W-1:0] p1_score;
  logic [SCORE_W-1:0] p2_score;
  logic               game_over;

  int error_count;
  int check_count;
  int test_count;
  int assert_fails;

  pong_top #(
    .GAME_SPEED (GAME_SPEED)
  ) i_pong_top (
    .clk         (clk),
    .i_rst       (rst),
    .i_start     (start),
    .i_p1_up     (p1_up),
    .i_p1_down   (p1_down),
    .i_p2_up     (p2_up),
    .i_p2_down   (p2_down),
    .o_hsync     (hsync),
    .o_vsync     (vsync),
    .o_vga_r     (vga_r),
    .o_vga_g     (vga_g),
    .o_vga_b     (vga_b),
    .o_p1_score  (p1_score),
    .o_p2_score  (p2_score),
    .o_game_over (game_over)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string test_name, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      $display("[ERROR] %s: expected %0d, actual %0d", test_name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string test_name, input int errors_before);
    test_count++;
    $display("test %s finished with %0d errors", test_name, error_count - errors_before);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  function automatic bit sync_level(input bit vertical);
    return vertical ? vsync : hsync;
  endfunction

  // expected sync level for a counter position, active low
  function automatic bit sync_expected(input int count, input int first, input int width);
    return !((count >= first) && (count < first + width));
  endfunction

  function automatic bit pixel_lit(input int col, input int row, input int p1_top,
                                   input int p2_top, input int ball_x, input int ball_y);
    int cx;
    int cy;
    cx = col >> CELL_SHIFT;
    cy = row >> CELL_SHIFT;
    if ((col >= ACTIVE_COLS) || (row >= ACTIVE_ROWS)) begin
      return 1'b0;
    end
    if ((cx == 0) && (cy >= p1_top) && (cy < p1_top + PADDLE_HEIGHT)) begin
      return 1'b1;
    end
    if ((cx == BOARD_W - 1) && (cy >= p2_top) && (cy < p2_top + PADDLE_HEIGHT)) begin
      return 1'b1;
    end
    return (cx == ball_x) && (cy == ball_y);
  endfunction

  task automatic wait_sync_fall(input bit vertical);
    int  cycles;
    bit  prev;
    bit  fall;
    cycles = 0;
    prev   = sync_level(vertical);
    do begin
      @(negedge clk);
      fall = prev && !sync_level(vertical);
      prev = sync_level(vertical);
      cycles++;
      if (!fall && (cycles > SYNC_TIMEOUT)) begin
        stop_on_timeout(vertical ? "vsync falling edge" : "hsync falling edge");
      end
    end while (!fall);
  endtask

  // low time and period, both in clock cycles
  task automatic measure_sync(input bit vertical, output int low_len, output int period);
    int cycles;
    bit prev;
    bit fall;
    wait_sync_fall(vertical);
    low_len = 0;
    cycles  = 0;
    prev    = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      if (sync_level(vertical) && !prev) begin
        low_len = cycles;
      end
      fall = prev && !sync_level(vertical);
      prev = sync_level(vertical);
      if (!fall && (cycles > SYNC_TIMEOUT)) begin
        stop_on_timeout("next sync falling edge");
      end
    end while (!fall);
    period = cycles;
  endtask

  // vsync falls on pixel column 0 of the first sync row
  task automatic scan_frame(input string test_name, input int p1_top, input int p2_top,
                            input int ball_x, input int ball_y);
    int i;
    int col;
    int row;
    int exp_rgb;
    int bad_pixels;
    int bad_syncs;
    wait_sync_fall(1'b1);
    col        = 0;
    row        = ACTIVE_ROWS + V_FRONT_PORCH;
    bad_pixels = 0;
    bad_syncs  = 0;
    for (i = 0; i < FRAME_CYCLES; i++) begin
      exp_rgb = pixel_lit(col, row, p1_top, p2_top, ball_x, ball_y) ? 7 : 0;
      if ((int'(vga_r) != exp_rgb) || (int'(vga_g) != exp_rgb) || (int'(vga_b) != exp_rgb)) begin
        bad_pixels++;
      end
      if ((hsync != sync_expected(col, ACTIVE_COLS + H_FRONT_PORCH, H_SYNC_WIDTH))
          || (vsync != sync_expected(row, ACTIVE_ROWS + V_FRONT_PORCH, V_SYNC_WIDTH))) begin
        bad_syncs++;
      end
      col++;
      if (col == TOTAL_COLS) begin
        col = 0;
        row = (row == TOTAL_ROWS - 1) ? 0 : row + 1;
      end
      @(negedge clk);
    end
    check_value({test_name, " wrong pixels"}, 0, bad_pixels);
    check_value({test_name, " wrong syncs"}, 0, bad_syncs);
  endtask

  task automatic wait_ticks(input int count);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < count) begin
      @(negedge clk);
      cycles++;
      if (i_pong_top.w_tick) begin
        seen++;
      end
      if ((seen < count) && (cycles > (count + 1) * GAME_SPEED)) begin
        stop_on_timeout("game ticks");
      end
    end
  endtask

  task automatic hold_buttons(input bit up1, input bit down1, input bit up2, input bit down2,
                              input int ticks);
    @(negedge clk);
    p1_up   = up1;
    p1_down = down1;
    p2_up   = up2;
    p2_down = down2;
    wait_ticks(ticks);
    // let the last tick be taken before release
    @(negedge clk);
    p1_up   = 1'b0;
    p1_down = 1'b0;
    p2_up   = 1'b0;
    p2_down = 1'b0;
  endtask

  task automatic press_start();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_score_change();
    int                 cycles;
    logic [SCORE_W-1:0] old_p1;
    logic [SCORE_W-1:0] old_p2;
    cycles = 0;
    old_p1 = p1_score;
    old_p2 = p2_score;
    while ((p1_score == old_p1) && (p2_score == old_p2)) begin
      @(negedge clk);
      cycles++;
      if (cycles > RALLY_TIMEOUT) begin
        stop_on_timeout("a score change");
      end
    end
  endtask

  task automatic after_reset();
    int errors_before;
    errors_before = error_count;
    check_value("after_reset red", 0, int'(vga_r));
    check_value("after_reset green", 0, int'(vga_g));
    check_value("after_reset blue", 0, int'(vga_b));
    check_value("after_reset hsync", 1, int'(hsync));
    check_value("after_reset vsync", 1, int'(vsync));
    check_value("after_reset p1 score", 0, int'(p1_score));
    check_value("after_reset p2 score", 0, int'(p2_score));
    check_value("after_reset game over", 0, int'(game_over));
    report_test("after_reset", errors_before);
  endtask

  task automatic sync_timing();
    int errors_before;
    int low_len;
    int period;
    errors_before = error_count;
    measure_sync(1'b0, low_len, period);
    check_value("sync_timing hsync low", H_SYNC_WIDTH, low_len);
    check_value("sync_timing hsync period", TOTAL_COLS, period);
    measure_sync(1'b1, low_len, period);
    check_value("sync_timing vsync low", V_SYNC_WIDTH * TOTAL_COLS, low_len);
    check_value("sync_timing vsync period", FRAME_CYCLES, period);
    report_test("sync_timing", errors_before);
  endtask

  task automatic paddle_drawing();
    int errors_before;
    errors_before = error_count;
    scan_frame("paddle_drawing", 12, 12, 20, 15);
    report_test("paddle_drawing", errors_before);
  endtask

  // more ticks than rows to the top, so the clamp holds it at 0
  task automatic paddle_clamp();
    int errors_before;
    errors_before = error_count;
    hold_buttons(1'b1, 1'b0, 1'b0, 1'b0, 20);
    scan_frame("paddle_clamp", 0, 12, 20, 15);
    report_test("paddle_clamp", errors_before);
  endtask

  task automatic miss_and_scoring();
    int errors_before;
    errors_before = error_count;
    // paddle 2 at the top, the ball arrives low on the right
    hold_buttons(1'b0, 1'b0, 1'b1, 1'b0, 30);
    press_start();
    wait_score_change();
    check_value("miss_and_scoring p1 score", 1, int'(p1_score));
    check_value("miss_and_scoring p2 score", 0, int'(p2_score));
    // both at the bottom, paddle 2 returns and paddle 1 misses
    hold_buttons(1'b0, 1'b1, 1'b0, 1'b1, 30);
    press_start();
    wait_score_change();
    check_value("miss_and_scoring p1 score after return", 1, int'(p1_score));
    check_value("miss_and_scoring p2 score after return", 1, int'(p2_score));
    report_test("miss_and_scoring", errors_before);
  endtask

  task automatic game_over_and_restart();
    int errors_before;
    int rallies;
    int cycles;
    errors_before = error_count;
    hold_buttons(1'b0, 1'b0, 1'b1, 1'b0, 30);
    rallies = 0;
    while ((int'(p1_score) < SCORE_TO_WIN) && (rallies < SCORE_TO_WIN)) begin
      press_start();
      wait_score_change();
      rallies++;
    end
    check_value("game_over p1 score", SCORE_TO_WIN, int'(p1_score));
    check_value("game_over p2 score", 1, int'(p2_score));
    check_value("game_over flag", 1, int'(game_over));
    press_start();
    cycles = 0;
    while (game_over) begin
      @(negedge clk);
      cycles++;
      if (cycles > 16) begin
        stop_on_timeout("game over to clear");
      end
    end
    check_value("game_over p1 score cleared", 0, int'(p1_score));
    check_value("game_over p2 score cleared", 0, int'(p2_score));
    report_test("game_over_and_restart", errors_before);
  endtask

  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    p1_up       = 1'b0;
    p1_down     = 1'b0;
    p2_up       = 1'b0;
    p2_down     = 1'b0;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    after_reset();
    sync_timing();
    paddle_drawing();
    paddle_clamp();
    miss_and_scoring();
    game_over_and_restart();
    assert_fails = i_pong_top.i_game_main.i_pong_assertions.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_count, check_count, error_count, assert_fails);
    if ((error_count == 0) && (assert_fails == 0)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/pong_assertions.sv */
// ------------------------------
// concurrent checks on the
// game controller, bound in
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module pong_assertions
  import pong_pkg::*;
#(
  parameter int SCORE_TO_WIN = 5
) (
  input wire               clk,
  input wire               i_rst,
  input wire               i_tick,
  input wire               i_miss_left,
  input wire               i_miss_right,
  input wire [SCORE_W-1:0] i_p1_score,
  input wire [SCORE_W-1:0] i_p2_score,
  input game_state_t       i_state
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  a_p1_score_limit: assert property (@(posedge clk) disable iff (i_rst)
    i_p1_score <= SCORE_W'(SCORE_TO_WIN))
    else begin
      $error("player 1 score above the winning score");
      fail_count++;
    end

  a_p2_score_limit: assert property (@(posedge clk) disable iff (i_rst)
    i_p2_score <= SCORE_W'(SCORE_TO_WIN))
    else begin
      $error("player 2 score above the winning score");
      fail_count++;
    end

  // tick is a single cycle pulse
  a_tick_pulse: assert property (@(posedge clk) disable iff (i_rst)
    !(i_tick && $past(i_tick)))
    else begin
      $error("game tick high for two cycles");
      fail_count++;
    end

  a_one_miss: assert property (@(posedge clk) disable iff (i_rst)
    !(i_miss_left && i_miss_right))
    else begin
      $error("both miss pulses high together");
      fail_count++;
    end

  // game over only with a winning score
  a_game_over_score: assert property (@(posedge clk) disable iff (i_rst)
    (i_state == ST_GAME_OVER) |->
      ((i_p1_score == SCORE_W'(SCORE_TO_WIN)) || (i_p2_score == SCORE_W'(SCORE_TO_WIN))))
    else begin
      $error("game over without a winning score");
      fail_count++;
    end

endmodule

bind game_main pong_assertions #(
  .SCORE_TO_WIN (SCORE_TO_WIN)
) i_pong_assertions (
  .clk          (clk),
  .i_rst        (i_rst),
  .i_tick       (o_tick),
  .i_miss_left  (i_miss_left),
  .i_miss_right (i_miss_right),
  .i_p1_score   (o_p1_score),
  .i_p2_score   (o_p2_score),
  .i_state      (r_state)
);

`default_nettype wire

/* source/pong_top.sv */
// ------------------------------
// pong top level
// timing, paddles, ball, control
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module pong_top
  import pong_pkg::*;
#(
  parameter int TOTAL_COLS    = 800,
  parameter int TOTAL_ROWS    = 525,
  parameter int ACTIVE_COLS   = 640,
  parameter int ACTIVE_ROWS   = 480,
  parameter int PADDLE_HEIGHT = 6,
  parameter int GAME_SPEED    = 1250000,
  parameter int SCORE_TO_WIN  = 5
) (
  input  wire                clk,
  input  wire                i_rst,
  input  wire                i_start,
  input  wire                i_p1_up,
  input  wire                i_p1_down,
  input  wire                i_p2_up,
  input  wire                i_p2_down,
  output logic               o_hsync,
  output logic               o_vsync,
  output logic [2:0]         o_vga_r,
  output logic [2:0]         o_vga_g,
  output logic [2:0]         o_vga_b,
  output logic [SCORE_W-1:0] o_p1_score,
  output logic [SCORE_W-1:0] o_p2_score,
  output logic               o_game_over
);

  // board size in cells
  localparam int BOARD_WIDTH  = ACTIVE_COLS >> CELL_SHIFT;
  localparam int BOARD_HEIGHT = ACTIVE_ROWS >> CELL_SHIFT;

  logic [CNT_W-1:0]  w_col;
  logic [CNT_W-1:0]  w_row;
  logic              w_active;
  logic              w_hsync;
  logic              w_vsync;
  logic              w_tick;
  logic              w_run;
  logic [CELL_W-1:0] w_paddle_y1;
  logic [CELL_W-1:0] w_paddle_y2;
  logic              w_draw_p1;
  logic              w_draw_p2;
  logic              w_draw_ball;
  logic              w_miss_left;
  logic              w_miss_right;

  vga_timing #(
    .TOTAL_COLS  (TOTAL_COLS),
    .TOTAL_ROWS  (TOTAL_ROWS),
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS)
  ) i_vga_timing (
    .clk      (clk),
    .i_rst    (i_rst),
    .o_col    (w_col),
    .o_row    (w_row),
    .o_active (w_active),
    .o_hsync  (w_hsync),
    .o_vsync  (w_vsync)
  );

  paddle_ctrl #(
    .PADDLE_COL    (0),
    .BOARD_HEIGHT  (BOARD_HEIGHT),
    .PADDLE_HEIGHT (PADDLE_HEIGHT)
  ) i_paddle_1 (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_tick     (w_tick),
    .i_up       (i_p1_up),
    .i_down     (i_p1_down),
    .i_col      (w_col),
    .i_row      (w_row),
    .i_active   (w_active),
    .o_paddle_y (w_paddle_y1),
    .o_draw     (w_draw_p1)
  );

  paddle_ctrl #(
    .PADDLE_COL    (BOARD_WIDTH - 1),
    .BOARD_HEIGHT  (BOARD_HEIGHT),
    .PADDLE_HEIGHT (PADDLE_HEIGHT)
  ) i_paddle_2 (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_tick     (w_tick),
    .i_up       (i_p2_up),
    .i_down     (i_p2_down),
    .i_col      (w_col),
    .i_row      (w_row),
    .i_active   (w_active),
    .o_paddle_y (w_paddle_y2),
    .o_draw     (w_draw_p2)
  );

  ball_ctrl #(
    .BOARD_WIDTH   (BOARD_WIDTH),
    .BOARD_HEIGHT  (BOARD_HEIGHT),
    .PADDLE_HEIGHT (PADDLE_HEIGHT)
  ) i_ball_ctrl (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_tick       (w_tick),
    .i_run        (w_run),
    .i_paddle_y1  (w_paddle_y1),
    .i_paddle_y2  (w_paddle_y2),
    .i_col        (w_col),
    .i_row        (w_row),
    .i_active     (w_active),
    .o_miss_left  (w_miss_left),
    .o_miss_right (w_miss_right),
    .o_draw       (w_draw_ball)
  );

  game_main #(
    .GAME_SPEED   (GAME_SPEED),
    .SCORE_TO_WIN (SCORE_TO_WIN)
  ) i_game_main (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_start      (i_start),
    .i_miss_left  (w_miss_left),
    .i_miss_right (w_miss_right),
    .i_draw_ball  (w_draw_ball),
    .i_draw_p1    (w_draw_p1),
    .i_draw_p2    (w_draw_p2),
    .i_hsync      (w_hsync),
    .i_vsync      (w_vsync),
    .o_tick       (w_tick),
    .o_run        (w_run),
    .o_hsync      (o_hsync),
    .o_vsync      (o_vsync),
    .o_vga_r      (o_vga_r),
    .o_vga_g      (o_vga_g),
    .o_vga_b      (o_vga_b),
    .o_p1_score   (o_p1_score),
    .o_p2_score   (o_p2_score),
    .o_game_over  (o_game_over)
  );

endmodule

`default_nettype wire

/* source/game_main.sv */
// ------------------------------
// game controller
// tick divider, state machine,
// scores, rgb and sync alignment
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module game_main
  import pong_pkg::*;
#(
  parameter int GAME_SPEED   = 1250000,
  parameter int SCORE_TO_WIN = 5
) (
  input  wire                clk,
  input  wire                i_rst,
  input  wire                i_start,
  input  wire                i_miss_left,
  input  wire                i_miss_right,
  input  wire                i_draw_ball,
  input  wire                i_draw_p1,
  input  wire                i_draw_p2,
  input  wire                i_hsync,
  input  wire                i_vsync,
  output logic               o_tick,
  output logic               o_run,
  output logic               o_hsync,
  output logic               o_vsync,
  output logic [2:0]         o_vga_r,
  output logic [2:0]         o_vga_g,
  output logic [2:0]         o_vga_b,
  output logic [SCORE_W-1:0] o_p1_score,
  output logic [SCORE_W-1:0] o_p2_score,
  output logic               o_game_over
);

  localparam int TICK_W = (GAME_SPEED > 1) ? $clog2(GAME_SPEED) : 1;

  game_state_t        r_state;
  logic [TICK_W-1:0]  r_tick_cnt;
  logic [SCORE_W-1:0] w_p1_next;
  logic [SCORE_W-1:0] w_p2_next;
  logic               w_draw;

  assign w_p1_next   = o_p1_score + 1'b1;
  assign w_p2_next   = o_p2_score + 1'b1;
  assign w_draw      = i_draw_ball | i_draw_p1 | i_draw_p2;
  assign o_run       = (r_state == ST_RUNNING);
  assign o_game_over = (r_state == ST_GAME_OVER);

  // free running game tick
  always_ff @(posedge clk) begin
    if (i_rst) begin
      r_tick_cnt <= '0;
      o_tick     <= 1'b0;
    end else if (r_tick_cnt == TICK_W'(GAME_SPEED - 1)) begin
      r_tick_cnt <= '0;
      o_tick     <= 1'b1;
    end else begin
      r_tick_cnt <= r_tick_cnt + 1'b1;
      o_tick     <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      r_state    <= ST_IDLE;
      o_p1_score <= '0;
      o_p2_score <= '0;
    end else begin
      unique case (r_state)
        ST_IDLE: begin
          if (i_start) begin
            r_state <= ST_RUNNING;
          end
        end
        ST_RUNNING: begin
          // a right miss is a point for player 1
          if (i_miss_right) begin
            r_state <= ST_P1_POINT;
          end else if (i_miss_left) begin
            r_state <= ST_P2_POINT;
          end
        end
        ST_P1_POINT: begin
          o_p1_score <= w_p1_next;
          r_state    <= (w_p1_next == SCORE_W'(SCORE_TO_WIN)) ? ST_GAME_OVER : ST_IDLE;
        end
        ST_P2_POINT: begin
          o_p2_score <= w_p2_next;
          r_state    <= (w_p2_next == SCORE_W'(SCORE_TO_WIN)) ? ST_GAME_OVER : ST_IDLE;
        end
        ST_GAME_OVER: begin
          if (i_start) begin
            o_p1_score <= '0;
            o_p2_score <= '0;
            r_state    <= ST_IDLE;
          end
        end
        default: begin
          r_state <= ST_IDLE;
        end
      endcase
    end
  end

  // syncs get one extra stage to match the rgb register
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_hsync <= 1'b1;
      o_vsync <= 1'b1;
      o_vga_r <= '0;
      o_vga_g <= '0;
      o_vga_b <= '0;
    end else begin
      o_hsync <= i_hsync;
      o_vsync <= i_vsync;
      o_vga_r <= w_draw ? 3'd7 : 3'd0;
      o_vga_g <= w_draw ? 3'd7 : 3'd0;
      o_vga_b <= w_draw ? 3'd7 : 3'd0;
    end
  end

endmodule

`default_nettype wire

/* source/ball_ctrl.sv */
// ------------------------------
// ball controller
// movement, wall and paddle
// bounce, miss pulses, draw flag
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ball_ctrl
  import pong_pkg::*;
#(
  parameter int BOARD_WIDTH   = 40,
  parameter int BOARD_HEIGHT  = 30,
  parameter int PADDLE_HEIGHT = 6
) (
  input  wire               clk,
  input  wire               i_rst,
  input  wire               i_tick,
  input  wire               i_run,
  input  wire  [CELL_W-1:0] i_paddle_y1,
  input  wire  [CELL_W-1:0] i_paddle_y2,
  input  wire  [CNT_W-1:0]  i_col,
  input  wire  [CNT_W-1:0]  i_row,
  input  wire               i_active,
  output logic              o_miss_left,
  output logic              o_miss_right,
  output logic              o_draw
);

  localparam int X_MAX   = BOARD_WIDTH - 1;
  localparam int Y_MAX   = BOARD_HEIGHT - 1;
  localparam int X_START = BOARD_WIDTH / 2;
  localparam int Y_START = BOARD_HEIGHT / 2;

  logic [CELL_W-1:0] r_ball_x;
  logic [CELL_W-1:0] r_ball_y;
  // 1 means right / down
  logic              r_dir_x;
  logic              r_dir_y;

  logic              w_dir_y;
  logic [CELL_W-1:0] w_x_next;
  logic [CELL_W-1:0] w_y_next;
  logic              w_hit_left;
  logic              w_hit_right;
  logic [CELL_W-1:0] w_cell_col;
  logic [CELL_W-1:0] w_cell_row;

  assign w_cell_col = CELL_W'(i_col >> CELL_SHIFT);
  assign w_cell_row = CELL_W'(i_row >> CELL_SHIFT);

  always_comb begin
    // wall bounce comes before the step
    w_dir_y = r_dir_y;
    if (r_ball_y == '0) begin
      w_dir_y = 1'b1;
    end else if (r_ball_y == CELL_W'(Y_MAX)) begin
      w_dir_y = 1'b0;
    end
    w_x_next = r_dir_x ? r_ball_x + 1'b1 : r_ball_x - 1'b1;
    w_y_next = w_dir_y ? r_ball_y + 1'b1 : r_ball_y - 1'b1;
    // paddle checks use the row the ball lands on
    w_hit_left  = (w_y_next >= i_paddle_y1)
               && (w_y_next < i_paddle_y1 + CELL_W'(PADDLE_HEIGHT));
    w_hit_right = (w_y_next >= i_paddle_y2)
               && (w_y_next < i_paddle_y2 + CELL_W'(PADDLE_HEIGHT));
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      r_ball_x     <= CELL_W'(X_START);
      r_ball_y     <= CELL_W'(Y_START);
      r_dir_x      <= 1'b1;
      r_dir_y      <= 1'b1;
      o_miss_left  <= 1'b0;
      o_miss_right <= 1'b0;
    end else begin
      o_miss_left  <= 1'b0;
      o_miss_right <= 1'b0;
      if (!i_run) begin
        // parked at the centre between rallies
        r_ball_x <= CELL_W'(X_START);
        r_ball_y <= CELL_W'(Y_START);
        r_dir_x  <= 1'b1;
        r_dir_y  <= 1'b1;
      end else if (i_tick) begin
        r_ball_x <= w_x_next;
        r_ball_y <= w_y_next;
        r_dir_y  <= w_dir_y;
        if (w_x_next == CELL_W'(X_MAX)) begin
          if (w_hit_right) begin
            r_dir_x <= 1'b0;
          end else begin
            o_miss_right <= 1'b1;
          end
        end else if (w_x_next == '0) begin
          if (w_hit_left) begin
            r_dir_x <= 1'b1;
          end else begin
            o_miss_left <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_draw <= 1'b0;
    end else begin
      o_draw <= i_active && (w_cell_col == r_ball_x) && (w_cell_row == r_ball_y);
    end
  end

endmodule

`default_nettype wire

/* source/paddle_ctrl.sv */
// ------------------------------
// single paddle controller
// clamped cell movement, draw flag
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module paddle_ctrl
  import pong_pkg::*;
#(
  parameter int PADDLE_COL    = 0,
  parameter int BOARD_HEIGHT  = 30,
  parameter int PADDLE_HEIGHT = 6
) (
  input  wire               clk,
  input  wire               i_rst,
  input  wire               i_tick,
  input  wire               i_up,
  input  wire               i_down,
  input  wire  [CNT_W-1:0]  i_col,
  input  wire  [CNT_W-1:0]  i_row,
  input  wire               i_active,
  output logic [CELL_W-1:0] o_paddle_y,
  output logic              o_draw
);

  // lowest legal top row, and the centred start row
  localparam int Y_MAX   = BOARD_HEIGHT - PADDLE_HEIGHT;
  localparam int Y_START = Y_MAX / 2;

  logic [CELL_W-1:0] w_cell_col;
  logic [CELL_W-1:0] w_cell_row;

  assign w_cell_col = CELL_W'(i_col >> CELL_SHIFT);
  assign w_cell_row = CELL_W'(i_row >> CELL_SHIFT);

  // up wins when both buttons are held
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_paddle_y <= CELL_W'(Y_START);
    end else if (i_tick) begin
      if (i_up) begin
        if (o_paddle_y != '0) begin
          o_paddle_y <= o_paddle_y - 1'b1;
        end
      end else if (i_down) begin
        if (o_paddle_y < CELL_W'(Y_MAX)) begin
          o_paddle_y <= o_paddle_y + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_draw <= 1'b0;
    end else begin
      o_draw <= i_active
             && (w_cell_col == CELL_W'(PADDLE_COL))
             && (w_cell_row >= o_paddle_y)
             && (w_cell_row < o_paddle_y + CELL_W'(PADDLE_HEIGHT));
    end
  end

endmodule

`default_nettype wire

/* source/vga_timing.sv */
// ------------------------------
// vga timing generator
// pixel counters, active flag,
// registered hsync and vsync
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module vga_timing
  import pong_pkg::*;
#(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  wire              clk,
  input  wire              i_rst,
  output logic [CNT_W-1:0] o_col,
  output logic [CNT_W-1:0] o_row,
  output logic             o_active,
  output logic             o_hsync,
  output logic             o_vsync
);

  localparam int HS_START = ACTIVE_COLS + H_FRONT_PORCH;
  localparam int HS_END   = HS_START + H_SYNC_WIDTH;
  localparam int VS_START = ACTIVE_ROWS + V_FRONT_PORCH;
  localparam int VS_END   = VS_START + V_SYNC_WIDTH;

  logic [CNT_W-1:0] w_col_next;
  logic [CNT_W-1:0] w_row_next;
  logic             w_line_end;

  always_comb begin
    w_line_end = (o_col == CNT_W'(TOTAL_COLS - 1));
    w_col_next = w_line_end ? '0 : o_col + 1'b1;
    w_row_next = o_row;
    if (w_line_end) begin
      if (o_row == CNT_W'(TOTAL_ROWS - 1)) begin
        w_row_next = '0;
      end else begin
        w_row_next = o_row + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_col    <= '0;
      o_row    <= '0;
      // pixel (0,0) is on screen
      o_active <= 1'b1;
      o_hsync  <= 1'b1;
      o_vsync  <= 1'b1;
    end else begin
      o_col    <= w_col_next;
      o_row    <= w_row_next;
      // decoded from the next count so it stays aligned with o_col and o_row
      o_active <= (w_col_next < CNT_W'(ACTIVE_COLS)) && (w_row_next < CNT_W'(ACTIVE_ROWS));
      // syncs trail the counters by one cycle, active low
      o_hsync  <= !((o_col >= CNT_W'(HS_START)) && (o_col < CNT_W'(HS_END)));
      o_vsync  <= !((o_row >= CNT_W'(VS_START)) && (o_row < CNT_W'(VS_END)));
    end
  end

endmodule

`default_nettype wire

/* source/pong_pkg.sv */
// ------------------------------
// shared pong definitions
// game state enum, cell geometry,
// vga porch and sync widths
// ------------------------------
`default_nettype none

package pong_pkg;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RUNNING,
    ST_P1_POINT,
    ST_P2_POINT,
    ST_GAME_OVER
  } game_state_t;

  // a cell is 16 by 16 pixels
  localparam int CELL_SHIFT = 4;

  // pixel counter, cell index and score widths
  localparam int CNT_W   = 10;
  localparam int CELL_W  = 6;
  localparam int SCORE_W = 4;

  // sync placement after the active area
  localparam int H_FRONT_PORCH = 16;
  localparam int H_SYNC_WIDTH  = 96;
  localparam int V_FRONT_PORCH = 10;
  localparam int V_SYNC_WIDTH  = 2;

endpackage

`default_nettype wire
